// File: filelist.f
+incdir+verification
design/cam_stage_pkg.sv
design/cam_match_array.sv
design/cam_config_writer.sv
design/lookup_ctrl.sv
design/cam_stage_top.sv
verification/tb_cam_stage.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_cam_stage
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_cam_stage_tasks.svh
`ifndef TB_CAM_STAGE_TASKS_SVH
`define TB_CAM_STAGE_TASKS_SVH

// ====================
// Error handling
// ====================
task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_equal(input string name, input logic [63:0] got,
        input logic [63:0] exp_val);
    assert (got === exp_val) else begin
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp_val);
        abort_run();
    end
endtask

task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", wait_limit, what);
    abort_run();
endtask

// ====================
// Control packets
// ====================
function automatic logic [ctrl_w-1:0] make_header(input logic [4:0] stage, input logic [2:0] lid,
        input logic [3:0] resv, input logic [15:0] flag, input logic [7:0] index);
    return {stage, lid, resv, 4'h0, flag, 24'h0, index};
endfunction

// Entry sits in the top bits after a byte swap, low VLAN nibble first
function automatic logic [ctrl_w-1:0] make_entry_beat(input int idx);
    logic [entry_w-1:0] entry;
    logic [ctrl_w-1:0]  word;
    logic [ctrl_w-1:0]  beat;
    entry = {ent_vlan[idx][3:0], ent_vlan[idx][vlan_w-1:4], ent_key[idx]};
    word  = {entry, 28'($urandom)};
    beat  = {<<8{word}};
    return beat;
endfunction

// Sends pkt_beats back to back, checks c_m_* one cycle later
task automatic send_ctrl_packet(input logic forwarded);
    for (int i = 0; i < pkt_beats.size(); i++) begin
        c_s_tvalid = 1'b1;
        c_s_tdata  = pkt_beats[i];
        c_s_tlast  = (i == pkt_beats.size() - 1);
        @(negedge clk);
        check_equal("c_m_tvalid", 64'(c_m_tvalid), 64'(forwarded));
        if (forwarded) begin
            check_equal("c_m_tdata", c_m_tdata, pkt_beats[i]);
            check_equal("c_m_tlast", 64'(c_m_tlast), 64'(c_s_tlast));
        end
    end
    c_s_tvalid = 1'b0;
    c_s_tlast  = 1'b0;
    @(negedge clk);
    check_equal("c_m_tvalid", 64'(c_m_tvalid), 64'(0));
endtask

// ====================
// Lookups
// ====================
task automatic wait_ready_out();
    int cycles;
    cycles = 0;
    while (ready_out !== 1'b1) begin
        @(negedge clk);
        cycles++;
        if (cycles > wait_limit) report_timeout("ready_out");
    end
endtask

task automatic wait_result(output int cycles);
    cycles = 0;
    while (phv_out_valid !== 1'b1) begin
        @(negedge clk);
        cycles++;
        if (cycles > wait_limit) report_timeout("phv_out_valid");
    end
endtask

task automatic check_result(input logic [phv_w-1:0] phv, input row_t r);
    check_equal("phv_out_valid", 64'(phv_out_valid), 64'(1));
    check_equal("ready_out", 64'(ready_out), 64'(0));
    check_equal("phv_out", phv_out, phv);
    check_equal("if_match", 64'(if_match), 64'(r.hit));
    check_equal("match_addr_out", 64'(match_addr_out), 64'(r.addr));
endtask

task automatic run_lookup(input row_t r);
    logic [phv_w-1:0] phv;
    int               stall;
    int               latency;
    phv = {$urandom, $urandom};
    phv[vlan_lsb +: vlan_w] = r.vlan;
    stall = (r.stall_max == 0) ? 0 : int'($urandom_range(32'(r.stall_max), 1));

    wait_ready_out();
    key_valid   = 1'b1;
    extract_key = r.key;
    phv_in      = phv;
    ready_in    = (stall == 0);
    @(negedge clk);
    key_valid = 1'b0;
    check_equal("ready_out", 64'(ready_out), 64'(0));

    wait_result(latency);
    if (stall == 0) begin
        check_equal("phv_out_valid latency", 64'(latency), 64'(2));
    end
    check_result(phv, r);
    // Sink stalls, the result has to hold
    for (int k = 0; k < stall; k++) begin
        @(negedge clk);
        check_result(phv, r);
    end
    ready_in = 1'b1;
    @(negedge clk);
    check_equal("phv_out_valid", 64'(phv_out_valid), 64'(0));
    check_equal("ready_out", 64'(ready_out), 64'(1));
endtask

`endif

// File: verification/tb_cam_stage.sv
`default_nettype none

module tb_cam_stage import cam_stage_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [1:0]        cfg;
        logic [key_w-1:0]  key;
        logic [vlan_w-1:0] vlan;
        logic [7:0]        stall_max;
        logic              hit;
        logic [addr_w-1:0] addr;
    } row_t;

    localparam int n_rows     = 17;
    localparam int wait_limit = 50;

    // Entry values used by config packets and lookups
    localparam logic [key_w-1:0] ent_key [7] = '{
        24'h1a2b3c, 24'h00ff10, 24'habcdef, 24'h5a5a5a, 24'h777001, 24'h0badc0, 24'hc0ffee
    };
    localparam logic [vlan_w-1:0] ent_vlan [7] = '{
        12'h0a5, 12'h123, 12'h7e1, 12'h010, 12'h3c4, 12'h808, 12'h246
    };

    logic              clk = 1'b0;
    logic              rst_n;
    logic [key_w-1:0]  extract_key;
    logic              key_valid;
    logic [phv_w-1:0]  phv_in;
    logic              ready_in;
    logic [ctrl_w-1:0] c_s_tdata;
    logic              c_s_tvalid;
    logic              c_s_tlast;
    logic              ready_out;
    logic [phv_w-1:0]  phv_out;
    logic              phv_out_valid;
    logic              if_match;
    logic [addr_w-1:0] match_addr_out;
    logic [ctrl_w-1:0] c_m_tdata;
    logic              c_m_tvalid;
    logic              c_m_tlast;

    row_t              rows [n_rows];
    logic [ctrl_w-1:0] pkt_beats [$];

    always #4 clk = ~clk;

    cam_stage_top #(
        .stage_id (5'd0)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .extract_key    (extract_key),
        .key_valid      (key_valid),
        .phv_in         (phv_in),
        .ready_in       (ready_in),
        .c_s_tdata      (c_s_tdata),
        .c_s_tvalid     (c_s_tvalid),
        .c_s_tlast      (c_s_tlast),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_out_valid  (phv_out_valid),
        .if_match       (if_match),
        .match_addr_out (match_addr_out),
        .c_m_tdata      (c_m_tdata),
        .c_m_tvalid     (c_m_tvalid),
        .c_m_tlast      (c_m_tlast)
    );

    `include "tb_cam_stage_tasks.svh"

    function automatic row_t make_row(input logic [1:0] cfg, input logic [key_w-1:0] key,
            input logic [vlan_w-1:0] vlan, input logic [7:0] stall_max, input logic hit,
            input logic [addr_w-1:0] addr);
        return '{cfg, key, vlan, stall_max, hit, addr};
    endfunction

    // ====================
    // Lookup table
    // ====================
    // cfg 1 writes entries 0..2 at 3, cfg 2 sends three foreign packets,
    // cfg 3 writes entry 6 twice at 12 and entry 0 again at 14
    // Last row looks up an all-zero word that no written entry holds
    task automatic fill_table();
        rows[0]  = make_row(2'd0, ent_key[0], ent_vlan[0], 8'd0, 1'b0, 4'd15);
        rows[1]  = make_row(2'd0, ent_key[1], ent_vlan[1], 8'd0, 1'b0, 4'd15);
        rows[2]  = make_row(2'd0, ent_key[6], ent_vlan[6], 8'd4, 1'b0, 4'd15);
        rows[3]  = make_row(2'd1, ent_key[0], ent_vlan[0], 8'd0, 1'b1, 4'd3);
        rows[4]  = make_row(2'd0, ent_key[1], ent_vlan[1], 8'd0, 1'b1, 4'd4);
        rows[5]  = make_row(2'd0, ent_key[2], ent_vlan[2], 8'd0, 1'b1, 4'd5);
        rows[6]  = make_row(2'd0, ent_key[0], 12'h0a6,     8'd0, 1'b0, 4'd15);
        rows[7]  = make_row(2'd2, ent_key[3], ent_vlan[3], 8'd0, 1'b0, 4'd15);
        rows[8]  = make_row(2'd0, ent_key[4], ent_vlan[4], 8'd0, 1'b0, 4'd15);
        rows[9]  = make_row(2'd0, ent_key[5], ent_vlan[5], 8'd0, 1'b0, 4'd15);
        rows[10] = make_row(2'd0, ent_key[2], ent_vlan[2], 8'd6, 1'b1, 4'd5);
        rows[11] = make_row(2'd0, ent_key[1], ent_vlan[1], 8'd6, 1'b1, 4'd4);
        rows[12] = make_row(2'd0, ent_key[3], ent_vlan[3], 8'd6, 1'b0, 4'd15);
        rows[13] = make_row(2'd3, ent_key[6], ent_vlan[6], 8'd0, 1'b1, 4'd12);
        rows[14] = make_row(2'd0, ent_key[0], ent_vlan[0], 8'd0, 1'b1, 4'd3);
        rows[15] = make_row(2'd0, ent_key[6], ent_vlan[6], 8'd3, 1'b1, 4'd12);
        rows[16] = make_row(2'd0, 24'h000000, 12'h000,     8'd0, 1'b0, 4'd15);
    endtask

    task automatic apply_config(input logic [1:0] cfg);
        case (cfg)
            2'd1: begin
                pkt_beats.delete();
                pkt_beats.push_back(make_header(5'd0, 3'd2, 4'h0, 16'hf2f1, 8'd3));
                pkt_beats.push_back(make_entry_beat(0));
                pkt_beats.push_back(make_entry_beat(1));
                pkt_beats.push_back(make_entry_beat(2));
                send_ctrl_packet(1'b0);
            end
            2'd2: begin
                // Wrong stage, wrong flag, nonzero resv
                pkt_beats.delete();
                pkt_beats.push_back(make_header(5'd1, 3'd2, 4'h0, 16'hf2f1, 8'd6));
                pkt_beats.push_back(make_entry_beat(3));
                send_ctrl_packet(1'b1);
                pkt_beats.delete();
                pkt_beats.push_back(make_header(5'd0, 3'd2, 4'h0, 16'hf2f0, 8'd7));
                pkt_beats.push_back(make_entry_beat(4));
                send_ctrl_packet(1'b1);
                pkt_beats.delete();
                pkt_beats.push_back(make_header(5'd0, 3'd2, 4'h8, 16'hf2f1, 8'd8));
                pkt_beats.push_back(make_entry_beat(5));
                send_ctrl_packet(1'b1);
            end
            2'd3: begin
                pkt_beats.delete();
                pkt_beats.push_back(make_header(5'd0, 3'd2, 4'h0, 16'hf2f1, 8'd12));
                pkt_beats.push_back(make_entry_beat(6));
                pkt_beats.push_back(make_entry_beat(6));
                pkt_beats.push_back(make_entry_beat(0));
                send_ctrl_packet(1'b0);
            end
            default: ;
        endcase
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(5909));
        rst_n       = 1'b0;
        extract_key = '0;
        key_valid   = 1'b0;
        phv_in      = '0;
        ready_in    = 1'b1;
        c_s_tdata   = '0;
        c_s_tvalid  = 1'b0;
        c_s_tlast   = 1'b0;
        fill_table();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_equal("phv_out_valid", 64'(phv_out_valid), 64'(0));
        check_equal("if_match", 64'(if_match), 64'(0));
        check_equal("c_m_tvalid", 64'(c_m_tvalid), 64'(0));
        check_equal("c_m_tlast", 64'(c_m_tlast), 64'(0));
        check_equal("wr_en", 64'(i_dut.wr_en), 64'(0));
        check_equal("ready_out", 64'(ready_out), 64'(1));

        for (int i = 0; i < n_rows; i++) begin
            apply_config(rows[i].cfg);
            run_lookup(rows[i]);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/cam_stage_top.sv
`default_nettype none

module cam_stage_top import cam_stage_pkg::*; #(
    parameter logic [stage_id_w-1:0] stage_id = '0
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [key_w-1:0]  extract_key,
    input  wire logic              key_valid,
    input  wire logic [phv_w-1:0]  phv_in,
    input  wire logic              ready_in,
    input  wire logic [ctrl_w-1:0] c_s_tdata,
    input  wire logic              c_s_tvalid,
    input  wire logic              c_s_tlast,
    output logic                   ready_out,
    output logic [phv_w-1:0]       phv_out,
    output logic                   phv_out_valid,
    output logic                   if_match,
    output logic [addr_w-1:0]      match_addr_out,
    output logic [ctrl_w-1:0]      c_m_tdata,
    output logic                   c_m_tvalid,
    output logic                   c_m_tlast
);

    logic [entry_w-1:0] cmp_key;
    logic               cmp_load;
    logic               match;
    logic [addr_w-1:0]  match_addr;
    logic               wr_en;
    logic [addr_w-1:0]  wr_addr;
    logic [entry_w-1:0] wr_data;

    // ====================
    // Lookup path
    // ====================
    lookup_ctrl i_lookup_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_valid      (key_valid),
        .extract_key    (extract_key),
        .phv_in         (phv_in),
        .ready_in       (ready_in),
        .match          (match),
        .match_addr     (match_addr),
        .ready_out      (ready_out),
        .cmp_key        (cmp_key),
        .cmp_load       (cmp_load),
        .phv_out        (phv_out),
        .phv_out_valid  (phv_out_valid),
        .if_match       (if_match),
        .match_addr_out (match_addr_out)
    );

    cam_match_array i_cam_match_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmp_key    (cmp_key),
        .cmp_load   (cmp_load),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .match      (match),
        .match_addr (match_addr)
    );

    // ====================
    // Control path
    // ====================
    cam_config_writer #(
        .stage_id (stage_id)
    ) i_cam_config_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .c_s_tdata  (c_s_tdata),
        .c_s_tvalid (c_s_tvalid),
        .c_s_tlast  (c_s_tlast),
        .c_m_tdata  (c_m_tdata),
        .c_m_tvalid (c_m_tvalid),
        .c_m_tlast  (c_m_tlast),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

endmodule

`default_nettype wire

// File: design/lookup_ctrl.sv
`default_nettype none

module lookup_ctrl import cam_stage_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              key_valid,
    input  wire logic [key_w-1:0]  extract_key,
    input  wire logic [phv_w-1:0]  phv_in,
    input  wire logic              ready_in,
    input  wire logic              match,
    input  wire logic [addr_w-1:0] match_addr,
    output logic                   ready_out,
    output logic [entry_w-1:0]     cmp_key,
    output logic                   cmp_load,
    output logic [phv_w-1:0]       phv_out,
    output logic                   phv_out_valid,
    output logic                   if_match,
    output logic [addr_w-1:0]      match_addr_out
);

    typedef enum logic [1:0] {
        s_idle,
        s_wait,
        s_halt
    } state_t;

    state_t            state;
    logic [vlan_w-1:0] vlan_id;
    logic [phv_w-1:0]  phv_reg;
    logic              accept;
    logic              result_rdy;

    assign vlan_id   = phv_in[vlan_lsb +: vlan_w];
    assign ready_out = (state == s_idle);
    assign accept    = key_valid && ready_out;

    // CAM result lands one cycle after the load pulse
    assign result_rdy = (state == s_wait) && !cmp_load;

    // ====================
    // Lookup FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= s_idle;
            cmp_load       <= 1'b0;
            phv_out_valid  <= 1'b0;
            if_match       <= 1'b0;
            match_addr_out <= miss_addr;
        end else begin
            cmp_load <= 1'b0;
            case (state)
                s_idle: begin
                    if (accept) begin
                        cmp_load <= 1'b1;
                        state    <= s_wait;
                    end
                end
                s_wait: begin
                    if (result_rdy) begin
                        phv_out_valid  <= 1'b1;
                        if_match       <= match;
                        match_addr_out <= match ? match_addr : miss_addr;
                        state          <= s_halt;
                    end
                end
                // Hold the result until the sink takes it
                s_halt: begin
                    if (ready_in) begin
                        phv_out_valid <= 1'b0;
                        state         <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Compare word puts the low VLAN nibble on top
    always_ff @(posedge clk) begin
        if (accept) begin
            phv_reg <= phv_in;
            cmp_key <= {vlan_id[3:0], vlan_id[vlan_w-1:4], extract_key};
        end
        if (result_rdy) begin
            phv_out <= phv_reg;
        end
    end

endmodule

`default_nettype wire

// File: design/cam_config_writer.sv
`default_nettype none

module cam_config_writer import cam_stage_pkg::*; #(
    parameter logic [stage_id_w-1:0] stage_id = '0
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [ctrl_w-1:0] c_s_tdata,
    input  wire logic              c_s_tvalid,
    input  wire logic              c_s_tlast,
    output logic [ctrl_w-1:0]      c_m_tdata,
    output logic                   c_m_tvalid,
    output logic                   c_m_tlast,
    output logic                   wr_en,
    output logic [addr_w-1:0]      wr_addr,
    output logic [entry_w-1:0]     wr_data
);

    typedef enum logic [1:0] {
        c_idle,
        c_entry,
        c_fwd
    } cstate_t;

    cstate_t                  state;
    logic [mod_id_w-1:0]      mod_id;
    logic [resv_w-1:0]        resv;
    logic [ctrl_flag_w-1:0]   ctrl_flag;
    logic [entry_index_w-1:0] entry_index;
    logic [ctrl_w-1:0]        swapped;
    logic                     hdr_match;
    logic                     fwd_beat;
    logic [addr_w-1:0]        wr_idx;

    // ====================
    // Header decode
    // ====================
    assign mod_id      = c_s_tdata[mod_id_lsb +: mod_id_w];
    assign resv        = c_s_tdata[resv_lsb +: resv_w];
    assign ctrl_flag   = c_s_tdata[ctrl_flag_lsb +: ctrl_flag_w];
    assign entry_index = c_s_tdata[entry_index_lsb +: entry_index_w];

    assign hdr_match = (mod_id[mod_id_w-1 -: stage_id_w] == stage_id)
                    && (mod_id[mod_id_w-stage_id_w-1:0] == lookup_id)
                    && (ctrl_flag == ctrl_magic)
                    && (resv == '0);

    // Host sends entries little endian
    always_comb begin
        for (int b = 0; b < ctrl_w / 8; b++) begin
            swapped[b*8 +: 8] = c_s_tdata[ctrl_w - 8 - b*8 +: 8];
        end
    end

    // Foreign header beat, or any beat of a packet already being forwarded
    assign fwd_beat = c_s_tvalid && (((state == c_idle) && !hdr_match) || (state == c_fwd));

    // ====================
    // Packet FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= c_idle;
            wr_en      <= 1'b0;
            wr_addr    <= '0;
            wr_idx     <= '0;
            c_m_tvalid <= 1'b0;
            c_m_tlast  <= 1'b0;
        end else begin
            wr_en      <= 1'b0;
            c_m_tvalid <= fwd_beat;
            c_m_tlast  <= fwd_beat && c_s_tlast;
            case (state)
                c_idle: begin
                    if (c_s_tvalid && !c_s_tlast) begin
                        state <= hdr_match ? c_entry : c_fwd;
                    end
                    if (c_s_tvalid && hdr_match) begin
                        wr_idx <= entry_index[addr_w-1:0];
                    end
                end
                c_entry: begin
                    if (c_s_tvalid) begin
                        wr_en   <= 1'b1;
                        wr_addr <= wr_idx;
                        wr_idx  <= wr_idx + addr_w'(1);
                        if (c_s_tlast) begin
                            state <= c_idle;
                        end
                    end
                end
                c_fwd: begin
                    if (c_s_tvalid && c_s_tlast) begin
                        state <= c_idle;
                    end
                end
                default: state <= c_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == c_entry) && c_s_tvalid) begin
            wr_data <= swapped[ctrl_w-1 -: entry_w];
        end
        if (fwd_beat) begin
            c_m_tdata <= c_s_tdata;
        end
    end

endmodule

`default_nettype wire

// File: design/cam_match_array.sv
`default_nettype none

module cam_match_array import cam_stage_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic [entry_w-1:0] cmp_key,
    input  wire logic               cmp_load,
    input  wire logic               wr_en,
    input  wire logic [addr_w-1:0]  wr_addr,
    input  wire logic [entry_w-1:0] wr_data,
    output logic                    match,
    output logic [addr_w-1:0]       match_addr
);

    logic [entry_w-1:0]   entries [cam_depth];
    logic [cam_depth-1:0] entry_valid;
    logic [cam_depth-1:0] hit;
    logic [addr_w-1:0]    first_hit;

    // ====================
    // Entry storage
    // ====================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_addr] <= wr_data;
        end
    end

    // Entries start out invalid, a write makes them live
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_addr] <= 1'b1;
        end
    end

    // ====================
    // Parallel compare
    // ====================
    always_comb begin
        for (int i = 0; i < cam_depth; i++) begin
            hit[i] = entry_valid[i] && (entries[i] == cmp_key);
        end
    end

    // Lowest address wins, so scan downward
    always_comb begin
        first_hit = '0;
        for (int i = cam_depth - 1; i >= 0; i--) begin
            if (hit[i]) begin
                first_hit = addr_w'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match      <= 1'b0;
            match_addr <= '0;
        end else if (cmp_load) begin
            match      <= |hit;
            match_addr <= first_hit;
        end
    end

endmodule

`default_nettype wire

// File: design/cam_stage_pkg.sv
`default_nettype none

package cam_stage_pkg;

    // ====================
    // Lookup datapath sizes
    // ====================
    localparam int key_w     = 24;
    localparam int vlan_w    = 12;
    localparam int entry_w   = key_w + vlan_w;
    localparam int phv_w     = 64;
    localparam int vlan_lsb  = 8;
    localparam int cam_depth = 16;
    localparam int addr_w    = 4;

    // Address reported when no entry hits
    localparam logic [addr_w-1:0] miss_addr = 4'd15;

    // ====================
    // Control stream
    // ====================
    localparam int ctrl_w = 64;

    // Header field positions, lsb and width
    localparam int mod_id_lsb      = 56;
    localparam int mod_id_w        = 8;
    localparam int stage_id_w      = 5;
    localparam int resv_lsb        = 52;
    localparam int resv_w          = 4;
    localparam int ctrl_flag_lsb   = 32;
    localparam int ctrl_flag_w     = 16;
    localparam int entry_index_lsb = 0;
    localparam int entry_index_w   = 8;

    // Marks a CAM config packet
    localparam logic [ctrl_flag_w-1:0] ctrl_magic = 16'hf2f1;

    // Module ID low bits that select this lookup
    localparam logic [mod_id_w-stage_id_w-1:0] lookup_id = 3'd2;

endpackage

`default_nettype wire
